/* hw/sbus_pkg.sv */
`default_nettype none

package sbus_pkg;

    // The payload layout below assumes a 64-bit bus
    localparam int DATA_W     = 64;
    localparam int MASK_W     = DATA_W / 8;
    localparam int ADDR_W     = 32;
    localparam int WORD_BYTES = 8;
    localparam int RAM_WORDS  = 256;
    localparam int RAM_IDX_W  = 8;

    // The RAM word index starts right above the byte offset in the address
    localparam int IDX_LSB    = $clog2(WORD_BYTES);

    // Header field widths
    localparam int ID_W       = 15;
    localparam int LEN_W      = 4;

    typedef enum logic [1:0] {
        REQ_READ_HDR   = 2'b00,
        REQ_WRITE_HDR  = 2'b01,
        REQ_WRITE_DATA = 2'b10,
        REQ_WRITE_LAST = 2'b11
    } req_tag_e;

    typedef enum logic [1:0] {
        RSP_WRITE_ACK  = 2'b00,
        RSP_READ_HDR   = 2'b01,
        RSP_READ_DATA  = 2'b10,
        RSP_READ_LAST  = 2'b11
    } rsp_tag_e;

    // Any nonzero mode field on the bus selects an incrementing burst
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } burst_mode_e;

    typedef struct packed {
        logic [1:0]        tag;
        logic [DATA_W-1:0] payload;
    } sbus_word_t;

    typedef struct packed {
        logic [MASK_W-1:0] mask;
        logic [ID_W-1:0]   id;
        logic [1:0]        mode;
        logic [2:0]        reserved;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
    } sbus_hdr_t;

    typedef struct packed {
        logic                 cs;
        logic                 we;
        logic [RAM_IDX_W-1:0] idx;
        logic [MASK_W-1:0]    mask;
        logic [DATA_W-1:0]    wdata;
    } ram_req_t;

endpackage

`default_nettype wire

/* hw/sbus_ram_bridge.sv */
`default_nettype none

module sbus_ram_bridge
(
    input  wire logic                        CLK,
    input  wire logic                        RST,

    input  wire sbus_pkg::sbus_word_t        req_word,
    input  wire logic                        req_valid,
    output logic                             req_ready,

    output sbus_pkg::sbus_word_t             rsp_word,
    output logic                             rsp_valid,
    input  wire logic                        rsp_ready,

    output sbus_pkg::ram_req_t               ram_req,
    input  wire logic [sbus_pkg::DATA_W-1:0] ram_rdata
);

    // Only one of a write burst, a pending acknowledge or a read burst is active
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_ACK,
        ST_READ
    } state_e;

    state_e                             state;
    state_e                             state_nxt;

    sbus_pkg::req_tag_e                 req_tag;
    sbus_pkg::sbus_hdr_t                req_hdr;
    sbus_pkg::sbus_hdr_t                rsp_hdr;

    // Fields captured from the most recent header
    logic [sbus_pkg::ID_W-1:0]          hdr_id;
    logic [sbus_pkg::MASK_W-1:0]        hdr_mask;
    sbus_pkg::burst_mode_e              hdr_mode;
    logic [sbus_pkg::RAM_IDX_W-1:0]     base_idx;

    logic [sbus_pkg::RAM_IDX_W-1:0]     ofs_step;
    logic [sbus_pkg::RAM_IDX_W-1:0]     wr_ofs;
    logic                               wr_first;
    logic [sbus_pkg::RAM_IDX_W-1:0]     rd_ofs;
    logic [sbus_pkg::RAM_IDX_W-1:0]     rd_ofs_nxt;
    logic [sbus_pkg::LEN_W-1:0]         rd_cnt;

    logic                               wr_hdr_acc;
    logic                               rd_hdr_req;
    logic                               rd_hdr_acc;
    logic                               wr_beat_acc;
    logic                               wr_last_acc;
    logic                               rd_last;
    logic                               rd_advance;
    logic                               rd_done;

    assign req_tag = sbus_pkg::req_tag_e'(req_word.tag);
    assign req_hdr = sbus_pkg::sbus_hdr_t'(req_word.payload);

    // Request decode

    assign wr_hdr_acc  = (state == ST_IDLE) && req_valid
                         && (req_tag == sbus_pkg::REQ_WRITE_HDR);
    assign rd_hdr_req  = (state == ST_IDLE) && req_valid
                         && (req_tag == sbus_pkg::REQ_READ_HDR);

    // The echo goes out in the same cycle, so a read header waits for rsp_ready
    assign rd_hdr_acc  = rd_hdr_req && rsp_ready;

    assign wr_beat_acc = (state == ST_WRITE) && req_valid
                         && ((req_tag == sbus_pkg::REQ_WRITE_DATA)
                             || (req_tag == sbus_pkg::REQ_WRITE_LAST));
    assign wr_last_acc = wr_beat_acc && (req_tag == sbus_pkg::REQ_WRITE_LAST);

    assign rd_last     = (rd_cnt == '0);
    assign rd_advance  = (state == ST_READ) && rsp_ready && !rd_last;
    assign rd_done     = (state == ST_READ) && rsp_ready && rd_last;

    assign req_ready   = wr_hdr_acc || rd_hdr_acc || wr_beat_acc;

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                if (wr_hdr_acc)
                    state_nxt = ST_WRITE;
                else if (rd_hdr_acc)
                    state_nxt = ST_READ;
            end
            ST_WRITE:
            begin
                if (wr_last_acc)
                    state_nxt = ST_ACK;
            end
            ST_ACK:
            begin
                if (rsp_ready)
                    state_nxt = ST_IDLE;
            end
            ST_READ:
            begin
                if (rd_done)
                    state_nxt = ST_IDLE;
            end
            default:
            begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // Header capture is shared by both directions
    always_ff @(posedge CLK)
    begin
        if (wr_hdr_acc || rd_hdr_acc)
        begin
            hdr_id   <= req_hdr.id;
            hdr_mask <= req_hdr.mask;
            base_idx <= req_hdr.addr[sbus_pkg::IDX_LSB +: sbus_pkg::RAM_IDX_W];
            if (req_hdr.mode == sbus_pkg::BURST_FIXED)
                hdr_mode <= sbus_pkg::BURST_FIXED;
            else
                hdr_mode <= sbus_pkg::BURST_INCR;
        end
    end

    // Offsets count in RAM words, and wrap with the RAM depth
    assign ofs_step = (hdr_mode == sbus_pkg::BURST_INCR) ? 1 : 0;

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            wr_ofs   <= '0;
            wr_first <= 1'b0;
        end
        else if (wr_hdr_acc)
        begin
            wr_ofs   <= '0;
            wr_first <= 1'b1;
        end
        else if (wr_beat_acc)
        begin
            wr_ofs   <= wr_ofs + ofs_step;
            wr_first <= 1'b0;
        end
    end

    // rd_ofs is the offset of the read whose data is on ram_rdata
    assign rd_ofs_nxt = rd_ofs + ofs_step;

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            rd_ofs <= '0;
            rd_cnt <= '0;
        end
        else if (rd_hdr_acc)
        begin
            rd_ofs <= '0;
            rd_cnt <= req_hdr.len;
        end
        else if (rd_advance)
        begin
            rd_ofs <= rd_ofs_nxt;
            rd_cnt <= rd_cnt - 1'b1;
        end
    end

    // RAM access

    always_comb
    begin
        ram_req.cs    = wr_beat_acc || rd_hdr_acc || rd_advance;
        ram_req.we    = wr_beat_acc;
        ram_req.mask  = wr_first ? hdr_mask : '1;
        ram_req.wdata = req_word.payload;

        // The first read of a burst takes its index straight from the header
        if (wr_beat_acc)
            ram_req.idx = base_idx + wr_ofs;
        else if (rd_hdr_acc)
            ram_req.idx = req_hdr.addr[sbus_pkg::IDX_LSB +: sbus_pkg::RAM_IDX_W];
        else
            ram_req.idx = base_idx + rd_ofs_nxt;
    end

    // Response word

    always_comb
    begin
        rsp_hdr          = '0;
        rsp_valid        = 1'b0;
        rsp_word.tag     = sbus_pkg::RSP_WRITE_ACK;
        rsp_word.payload = '0;
        case (state)
            ST_IDLE:
            begin
                // Echo of a read header, valid for as long as the header is presented
                rsp_hdr.id       = req_hdr.id;
                rsp_valid        = rd_hdr_req;
                rsp_word.tag     = sbus_pkg::RSP_READ_HDR;
                rsp_word.payload = rsp_hdr;
            end
            ST_READ:
            begin
                rsp_valid        = 1'b1;
                rsp_word.tag     = rd_last ? sbus_pkg::RSP_READ_LAST
                                           : sbus_pkg::RSP_READ_DATA;
                rsp_word.payload = ram_rdata;
            end
            ST_ACK:
            begin
                rsp_hdr.id       = hdr_id;
                rsp_valid        = 1'b1;
                rsp_word.tag     = sbus_pkg::RSP_WRITE_ACK;
                rsp_word.payload = rsp_hdr;
            end
            default:
            begin
                rsp_valid        = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/sbus_sram.sv */
`default_nettype none

module sbus_sram
(
    input  wire logic                    CLK,
    input  wire sbus_pkg::ram_req_t      ram_req,
    output logic [sbus_pkg::DATA_W-1:0]  ram_rdata
);

    // One bus word per entry, indexed by word and not by byte
    logic [sbus_pkg::DATA_W-1:0] mem [sbus_pkg::RAM_WORDS];

    logic                        wr_en;
    logic                        rd_en;

    assign wr_en = ram_req.cs && ram_req.we;
    assign rd_en = ram_req.cs && !ram_req.we;

    // Each enabled byte lane updates its own slice of the addressed word
    always_ff @(posedge CLK)
    begin
        if (wr_en)
        begin
            for (int lane = 0; lane < sbus_pkg::MASK_W; lane++)
            begin
                if (ram_req.mask[lane])
                begin
                    mem[ram_req.idx][lane*8 +: 8] <= ram_req.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Read data appears one cycle after the access
    // and stays put while the RAM is not selected
    always_ff @(posedge CLK)
    begin
        if (rd_en)
        begin
            ram_rdata <= mem[ram_req.idx];
        end
    end

endmodule

`default_nettype wire

/* hw/sbus_ram_subsys.sv */
`default_nettype none

module sbus_ram_subsys
(
    input  wire logic                  CLK,
    input  wire logic                  RST,

    input  wire sbus_pkg::sbus_word_t  req_word,
    input  wire logic                  req_valid,
    output logic                       req_ready,

    output sbus_pkg::sbus_word_t       rsp_word,
    output logic                       rsp_valid,
    input  wire logic                  rsp_ready
);

    // Bridge to RAM port
    sbus_pkg::ram_req_t                ram_req;
    logic [sbus_pkg::DATA_W-1:0]       ram_rdata;

    sbus_ram_bridge u_bridge
    (
        .CLK       (CLK),
        .RST       (RST),
        .req_word  (req_word),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_word  (rsp_word),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

    sbus_sram u_sram
    (
        .CLK       (CLK),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* bench/sbus_ram_subsys_tb.sv */
`default_nettype none

module sbus_ram_subsys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // Fill, five directed tests, then eight random pairs of up to 4 write and 8 read beats
    localparam int TEST_BEATS     = 256 + 2 + 4 + 8 + 6 + 4 + 8 * (4 + 8);
    localparam int TIMEOUT_CYCLES = 2 * TEST_BEATS + 200;

    logic                        CLK;
    logic                        RST;
    sbus_pkg::sbus_word_t        req_word;
    logic                        req_valid;
    logic                        req_ready;
    sbus_pkg::sbus_word_t        rsp_word;
    logic                        rsp_valid;
    logic                        rsp_ready;

    integer                      seed = 32'h1ec0bdc8;
    logic                        random_ready;
    int                          cycle_count;
    int                          errors;
    int                          err_mark;
    int                          tests_passed;
    int                          tests_failed;

    // Shadow copy of the RAM, indexed by word
    logic [sbus_pkg::DATA_W-1:0] shadow [int];

    // Responses still to come, in order
    sbus_pkg::sbus_word_t        exp_q [$];
    sbus_pkg::sbus_word_t        exp_head;
    logic                        exp_avail;

    sbus_ram_subsys dut
    (
        .CLK       (CLK),
        .RST       (RST),
        .req_word  (req_word),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_word  (rsp_word),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    always #2 CLK = ~CLK;

    // Backpressure is either always ready or ready about three cycles in four
    always @(negedge CLK)
    begin
        if (random_ready)
            rsp_ready = (($random(seed) & 3) != 0);
        else
            rsp_ready = 1'b1;
    end

    function automatic void refresh_head();
        exp_avail = (exp_q.size() != 0);
        exp_head  = exp_avail ? exp_q[0] : '0;
    endfunction

    always @(posedge CLK)
    begin
        if (!RST && rsp_valid && rsp_ready && exp_q.size() != 0)
        begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_rsp_expected: assert property (@(posedge CLK) disable iff (RST)
        rsp_valid && rsp_ready |-> exp_avail)
    else
    begin
        $display("a response was accepted while none was outstanding at %0t", $time);
        errors++;
    end

    a_rsp_value: assert property (@(posedge CLK) disable iff (RST)
        rsp_valid && rsp_ready && exp_avail |-> rsp_word == exp_head)
    else
    begin
        $display("FAILED %0t: response %h, expected %h", $time,
                 $sampled(rsp_word), $sampled(exp_head));
        errors++;
    end

    a_rsp_hold: assert property (@(posedge CLK) disable iff (RST)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_word))
    else
    begin
        $display("a response was withdrawn or changed before acceptance at %0t", $time);
        errors++;
    end

    // Only the read echo may go out in the same cycle as a request
    a_busy_no_req: assert property (@(posedge CLK) disable iff (RST)
        rsp_valid && rsp_word.tag != sbus_pkg::RSP_READ_HDR |-> !(req_valid && req_ready))
    else
    begin
        $display("a request was accepted while a response was pending at %0t", $time);
        errors++;
    end

    a_reset_quiet: assert property (@(posedge CLK)
        RST |-> !req_ready && !rsp_valid)
    else
    begin
        $display("the bus handshakes were active during reset at %0t", $time);
        errors++;
    end

    function automatic void expect_rsp(input logic [1:0] tag, input logic [63:0] payload);
        sbus_pkg::sbus_word_t w;
        w.tag     = tag;
        w.payload = payload;
        exp_q.push_back(w);
        refresh_head();
    endfunction

    function automatic logic [63:0] id_only(input logic [14:0] id);
        sbus_pkg::sbus_hdr_t h;
        h    = '0;
        h.id = id;
        return h;
    endfunction

    function automatic logic [63:0] make_hdr(input logic [7:0] mask, input logic [14:0] id,
                                             input logic [1:0] mode, input logic [3:0] len,
                                             input logic [31:0] addr);
        sbus_pkg::sbus_hdr_t h;
        h      = '0;
        h.mask = mask;
        h.id   = id;
        h.mode = mode;
        h.len  = len;
        h.addr = addr;
        return h;
    endfunction

    // High address bits fall away and the index wraps with the RAM depth
    function automatic int word_index(input logic [31:0] addr);
        return int'(addr / sbus_pkg::WORD_BYTES) % sbus_pkg::RAM_WORDS;
    endfunction

    function automatic void shadow_write(input int idx, input logic [7:0] mask,
                                         input logic [63:0] data);
        logic [63:0] word;
        word = shadow.exists(idx) ? shadow[idx] : '0;
        for (int lane = 0; lane < sbus_pkg::MASK_W; lane++)
        begin
            if (mask[lane])
                word[lane*8 +: 8] = data[lane*8 +: 8];
        end
        shadow[idx] = word;
    endfunction

    task automatic drive_word(input logic [1:0] tag, input logic [63:0] payload);
        @(negedge CLK);
        req_word.tag     = tag;
        req_word.payload = payload;
        req_valid        = 1'b1;
        @(posedge CLK);
        while (!req_ready)
            @(posedge CLK);
    endtask

    task automatic write_burst(input logic [31:0] addr, input logic [1:0] mode,
                               input logic [7:0] mask, input logic [14:0] id,
                               input int beats, input logic [63:0] base);
        int          idx;
        logic [63:0] data;
        idx = word_index(addr);
        expect_rsp(sbus_pkg::RSP_WRITE_ACK, id_only(id));
        drive_word(sbus_pkg::REQ_WRITE_HDR, make_hdr(mask, id, mode, 4'd0, addr));
        for (int i = 0; i < beats; i++)
        begin
            data = base + i * 64'h0101_0101_0000_0001;
            drive_word((i == beats - 1) ? sbus_pkg::REQ_WRITE_LAST
                                        : sbus_pkg::REQ_WRITE_DATA, data);
            // The header mask covers the first beat only
            shadow_write(idx, (i == 0) ? mask : 8'hff, data);
            if (mode != sbus_pkg::BURST_FIXED)
                idx = (idx + 1) % sbus_pkg::RAM_WORDS;
        end
    endtask

    task automatic read_burst(input logic [31:0] addr, input logic [1:0] mode,
                              input logic [3:0] len, input logic [14:0] id);
        int idx;
        idx = word_index(addr);
        expect_rsp(sbus_pkg::RSP_READ_HDR, id_only(id));
        for (int i = 0; i <= len; i++)
        begin
            expect_rsp((i == len) ? sbus_pkg::RSP_READ_LAST : sbus_pkg::RSP_READ_DATA,
                       shadow[idx]);
            if (mode != sbus_pkg::BURST_FIXED)
                idx = (idx + 1) % sbus_pkg::RAM_WORDS;
        end
        drive_word(sbus_pkg::REQ_READ_HDR, make_hdr(8'h00, id, mode, len, addr));
    endtask

    // Two quiet cycles at the end let a surplus response show up
    task automatic drain();
        @(negedge CLK);
        req_valid = 1'b0;
        while (exp_q.size() != 0)
            @(posedge CLK);
        repeat (2) @(posedge CLK);
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: responses stopped arriving");
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0] addr;
        logic [1:0]  mode;
        logic [7:0]  mask;
        logic [14:0] id;
        logic [63:0] base;
        int          wlen;
        logic [3:0]  rlen;

        CLK          = 1'b0;
        RST          = 1'b1;
        req_word     = '0;
        req_valid    = 1'b0;
        rsp_ready    = 1'b0;
        random_ready = 1'b0;
        errors       = 0;
        err_mark     = 0;
        tests_passed = 0;
        tests_failed = 0;
        refresh_head();
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;

        // Every RAM word starts out with a value that depends on its index
        write_burst(32'h0, 2'b01, 8'hff, 15'h0001, sbus_pkg::RAM_WORDS, 64'h5a00_0000_a500_0000);
        drain();
        end_test("fill");

        write_burst(32'h40, 2'b01, 8'hff, 15'h0011, 1, 64'h0123_4567_89ab_cdef);
        read_burst(32'h40, 2'b01, 4'd0, 15'h0012);
        drain();
        end_test("single beat");

        write_burst(32'h80, 2'b01, 8'h0f, 15'h0021, 2, 64'hdead_beef_cafe_f00d);
        read_burst(32'h80, 2'b01, 4'd1, 15'h0022);
        drain();
        end_test("byte mask");

        write_burst(32'h100, 2'b01, 8'hff, 15'h0031, 4, 64'h1111_2222_3333_4444);
        read_burst(32'h100, 2'b01, 4'd3, 15'h0032);
        drain();
        end_test("incrementing burst");

        // The read also covers the words on either side of the fixed address
        write_burst(32'h200, 2'b00, 8'hff, 15'h0041, 3, 64'h7777_0000_8888_0000);
        read_burst(32'h1f8, 2'b01, 4'd2, 15'h0042);
        drain();
        end_test("fixed burst");

        write_burst(32'hffff_07f8, 2'b01, 8'hff, 15'h0051, 2, 64'h0bad_f00d_0000_1000);
        read_burst(32'h0000_07f8, 2'b11, 4'd1, 15'h0052);
        drain();
        end_test("address wrap");

        random_ready = 1'b1;
        for (int n = 0; n < 8; n++)
        begin
            addr         = $random(seed);
            mode         = $random(seed);
            mask         = $random(seed);
            id           = $random(seed);
            base[63:32]  = $random(seed);
            base[31:0]   = $random(seed);
            wlen         = 1 + ($random(seed) & 3);
            rlen         = $random(seed) & 7;
            write_burst(addr, mode, mask, id, wlen, base);
            read_burst(addr, mode, rlen, id + 15'd1);
        end
        drain();
        end_test("random backpressure");

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/sbus_pkg.sv
hw/sbus_ram_bridge.sv
hw/sbus_sram.sv
hw/sbus_ram_subsys.sv
bench/sbus_ram_subsys_tb.sv

/* Bender.yml */
package:
  name: sbus_ram_subsys

sources:
  # RTL in compile order, the package first
  - files:
      - hw/sbus_pkg.sv
      - hw/sbus_ram_bridge.sv
      - hw/sbus_sram.sv
      - hw/sbus_ram_subsys.sv

  # Testbench
  - target: test
    files:
      - bench/sbus_ram_subsys_tb.sv
